// File: hw/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// Processor address split into line tag and byte offset
`define DCACHE_ADDR_BITS    32
`define DCACHE_OFFSET_BITS  3
`define DCACHE_TAG_BITS     29

// Line and word geometry
`define DCACHE_LINE_BYTES   8
`define DCACHE_WORD_BITS    32

// Capacity and miss tracking
`define DCACHE_LINES        8
`define DCACHE_MSHR_DEPTH   4

// Memory tag zero means no tag
`define DCACHE_MEM_TAG_BITS 4

`define DCACHE_READ_PORTS   2

`endif

// File: hw/dcache_pkg.sv
`include "dcache_settings.svh"

package dcache_pkg;

    // One line as bytes, byte 0 in the low bits
    typedef logic [`DCACHE_LINE_BYTES-1:0][7:0] line_data_t;

    // One bit per cache line
    typedef logic [`DCACHE_LINES-1:0] line_mask_t;

    typedef struct packed {
        logic                           valid;
        logic [`DCACHE_TAG_BITS-1:0]    tag;
        logic [`DCACHE_OFFSET_BITS-1:0] offset;
    } addr_pkt_t;

    typedef struct packed {
        logic                        valid;
        logic                        dirty;
        logic [`DCACHE_TAG_BITS-1:0] tag;
        line_data_t                  data;
    } cache_line_t;

    typedef struct packed {
        logic       valid;
        line_data_t data;
    } lookup_t;

    // Store already placed at its position within the line
    typedef struct packed {
        logic                          valid;
        logic [`DCACHE_TAG_BITS-1:0]   tag;
        logic [`DCACHE_LINE_BYTES-1:0] byte_en;
        line_data_t                    data;
    } store_req_t;

    typedef struct packed {
        logic                            valid;
        logic [`DCACHE_MEM_TAG_BITS-1:0] mem_tag;
        logic [`DCACHE_TAG_BITS-1:0]     tag;
    } mshr_entry_t;

    typedef struct packed {
        logic                        valid;
        logic [`DCACHE_TAG_BITS-1:0] tag;
        line_data_t                  data;
    } mem_wb_t;

    // Miss sources in falling priority
    typedef enum logic [1:0] {
        MISS_NONE  = 2'd0,
        MISS_STORE = 2'd1,
        MISS_LOAD0 = 2'd2,
        MISS_LOAD1 = 2'd3
    } miss_src_t;

endpackage

// File: hw/dcache_replace.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_replace
    import dcache_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  line_mask_t valid_bits,
    output line_mask_t write_sel,
    output logic       evict
);

    localparam int LFSR_BITS = 16;
    localparam logic [LFSR_BITS-1:0] LFSR_SEED = 16'hace1;
    localparam int IDX_BITS = $clog2(`DCACHE_LINES);

    logic [LFSR_BITS-1:0] lfsr;
    logic [IDX_BITS-1:0]  victim_idx;
    logic                 free_found;

    // x^16 + x^15 + x^13 + x^4 + 1, steps every cycle
    always_ff @(posedge clock) begin
        if (!reset) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[LFSR_BITS-2:0], lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3]};
        end
    end

    assign victim_idx = lfsr[IDX_BITS-1:0];
    assign evict = &valid_bits;

    // Lowest free line wins, random victim only when the cache is full
    always_comb begin
        write_sel = '0;
        free_found = 1'b0;
        for (int i = 0; i < `DCACHE_LINES; i++) begin
            if (!valid_bits[i] && !free_found) begin
                write_sel[i] = 1'b1;
                free_found = 1'b1;
            end
        end
        if (evict) begin
            write_sel[victim_idx] = 1'b1;
        end
    end

endmodule

// File: hw/dcache_lines.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_lines
    import dcache_pkg::*;
(
    input  logic                                  clock,
    input  logic                                  reset,

    // Load lookups
    input  addr_pkt_t [`DCACHE_READ_PORTS-1:0]    read_addrs,
    output lookup_t   [`DCACHE_READ_PORTS-1:0]    cache_outs,

    // Store update, applied on a hit only
    input  store_req_t                            store_req,
    input  logic                                  store_en,
    output logic                                  store_hit,

    // Refill from memory
    input  addr_pkt_t                             refill,
    input  line_data_t                            refill_data,

    // Dirty victim, one cycle after the refill edge
    output mem_wb_t                               mem_wb
);

    localparam int IDX_BITS = $clog2(`DCACHE_LINES);

    cache_line_t [`DCACHE_LINES-1:0] lines;
    cache_line_t                     line_wdata;
    line_mask_t                      line_we;
    line_mask_t                      valid_bits;
    line_mask_t                      write_sel;
    logic                            evict;
    logic [IDX_BITS-1:0]             hit_idx;
    logic [IDX_BITS-1:0]             victim_idx;
    line_data_t                      merged;
    mem_wb_t                         wb_next;

    always_comb begin
        for (int i = 0; i < `DCACHE_LINES; i++) begin
            valid_bits[i] = lines[i].valid;
        end
    end

    dcache_replace i_dcache_replace (
        .clock     (clock),
        .reset     (reset),
        .valid_bits(valid_bits),
        .write_sel (write_sel),
        .evict     (evict)
    );

    // Fully associative compare per load port
    always_comb begin
        cache_outs = '0;
        for (int p = 0; p < `DCACHE_READ_PORTS; p++) begin
            for (int i = 0; i < `DCACHE_LINES; i++) begin
                if (read_addrs[p].valid && lines[i].valid &&
                    (lines[i].tag == read_addrs[p].tag)) begin
                    cache_outs[p].valid = 1'b1;
                    cache_outs[p].data  = lines[i].data;
                end
            end
        end
    end

    // Store tag compare
    always_comb begin
        store_hit = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < `DCACHE_LINES; i++) begin
            if (store_req.valid && lines[i].valid && (lines[i].tag == store_req.tag)) begin
                store_hit = 1'b1;
                hit_idx = IDX_BITS'(i);
            end
        end
    end

    // Index of the refill slot, needed to read out the victim
    always_comb begin
        victim_idx = '0;
        for (int i = 0; i < `DCACHE_LINES; i++) begin
            if (write_sel[i]) begin
                victim_idx = IDX_BITS'(i);
            end
        end
    end

    // Byte merge of the store into the hit line
    always_comb begin
        merged = lines[hit_idx].data;
        for (int b = 0; b < `DCACHE_LINE_BYTES; b++) begin
            if (store_req.byte_en[b]) begin
                merged[b] = store_req.data[b];
            end
        end
    end

    // Refill has priority over a store in the same cycle
    always_comb begin
        line_we = '0;
        line_wdata = '0;
        wb_next = '0;
        if (refill.valid) begin
            line_we = write_sel;
            line_wdata.valid = 1'b1;
            line_wdata.dirty = 1'b0;
            line_wdata.tag = refill.tag;
            line_wdata.data = refill_data;
            // Capture the victim now, the slot is overwritten at this edge
            wb_next.valid = evict && lines[victim_idx].valid && lines[victim_idx].dirty;
            wb_next.tag = lines[victim_idx].tag;
            wb_next.data = lines[victim_idx].data;
        end else if (store_en && store_hit) begin
            line_we[hit_idx] = 1'b1;
            line_wdata = lines[hit_idx];
            line_wdata.data = merged;
            // Rewriting identical data leaves a clean line clean
            line_wdata.dirty = lines[hit_idx].dirty || (merged != lines[hit_idx].data);
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < `DCACHE_LINES; i++) begin
            if (!reset) begin
                lines[i].valid <= 1'b0;
                lines[i].dirty <= 1'b0;
            end else if (line_we[i]) begin
                lines[i] <= line_wdata;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            mem_wb.valid <= 1'b0;
        end else begin
            mem_wb <= wb_next;
        end
    end

endmodule

// File: hw/dcache_mshr.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_mshr
    import dcache_pkg::*;
(
    input  logic                            clock,
    input  logic                            reset,

    // Duplicate check against outstanding lines
    input  logic [`DCACHE_TAG_BITS-1:0]     snoop_tag,
    output logic                            found,

    // Accepted request
    input  mshr_entry_t                     new_entry,

    // Data return, retires the head in order
    input  logic [`DCACHE_MEM_TAG_BITS-1:0] mem_data_tag,
    output addr_pkt_t                       refill
);

    localparam int PTR_BITS = $clog2(`DCACHE_MSHR_DEPTH);

    mshr_entry_t [`DCACHE_MSHR_DEPTH-1:0] entries;
    logic [PTR_BITS-1:0]                  head;
    logic [PTR_BITS-1:0]                  tail;
    logic                                 pop;

    function automatic logic [PTR_BITS-1:0] ptr_next(input logic [PTR_BITS-1:0] ptr);
        ptr_next = (ptr == PTR_BITS'(`DCACHE_MSHR_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_comb begin
        found = 1'b0;
        for (int i = 0; i < `DCACHE_MSHR_DEPTH; i++) begin
            if (entries[i].valid && (entries[i].tag == snoop_tag)) begin
                found = 1'b1;
            end
        end
    end

    // Only the head can retire, memory answers in request order
    assign pop = (mem_data_tag != '0) && entries[head].valid &&
                 (entries[head].mem_tag == mem_data_tag);

    always_comb begin
        refill = '0;
        refill.valid = pop;
        refill.tag = entries[head].tag;
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < `DCACHE_MSHR_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            if (pop) begin
                entries[head].valid <= 1'b0;
                head <= ptr_next(head);
            end
            if (new_entry.valid) begin
                entries[tail] <= new_entry;
                tail <= ptr_next(tail);
            end
        end
    end

endmodule

// File: hw/dcache_miss_ctrl.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_miss_ctrl
    import dcache_pkg::*;
(
    // Store port
    input  logic                                 store_valid,
    input  logic [`DCACHE_ADDR_BITS-1:0]         store_addr,
    input  logic [`DCACHE_WORD_BITS-1:0]         store_data,

    // Load ports and their lookup results
    input  addr_pkt_t [`DCACHE_READ_PORTS-1:0]   read_addrs,
    input  lookup_t   [`DCACHE_READ_PORTS-1:0]   cache_outs,

    input  logic                                 store_hit,
    input  logic                                 refill_active,
    input  logic                                 mshr_found,
    input  logic                                 mem_wb_valid,
    input  logic                                 mem_req_accepted,
    input  logic [`DCACHE_MEM_TAG_BITS-1:0]      current_req_tag,

    output store_req_t                           store_req,
    output logic                                 store_en,
    output logic                                 store_done,
    output logic [`DCACHE_TAG_BITS-1:0]          snoop_tag,
    output addr_pkt_t                            mem_req,
    output mshr_entry_t                          new_entry
);

    localparam int WORD_BYTES = `DCACHE_WORD_BITS / 8;

    miss_src_t                   miss_src;
    logic [`DCACHE_TAG_BITS-1:0] miss_tag;
    logic                        upper_word;

    // Word select within the line
    assign upper_word = store_addr[`DCACHE_OFFSET_BITS-1];

    always_comb begin
        store_req.valid = store_valid;
        store_req.tag = store_addr[`DCACHE_ADDR_BITS-1:`DCACHE_OFFSET_BITS];
        store_req.byte_en = {{WORD_BYTES{upper_word}}, {WORD_BYTES{!upper_word}}};
        store_req.data = upper_word ? {store_data, {`DCACHE_WORD_BITS{1'b0}}}
                                    : {{`DCACHE_WORD_BITS{1'b0}}, store_data};
    end

    // A store during a refill is held off and retried by the source
    assign store_en = store_valid && store_hit && !refill_active;
    assign store_done = store_en;

    always_comb begin
        if (store_valid && !store_hit) begin
            miss_src = MISS_STORE;
        end else if (read_addrs[0].valid && !cache_outs[0].valid) begin
            miss_src = MISS_LOAD0;
        end else if (read_addrs[1].valid && !cache_outs[1].valid) begin
            miss_src = MISS_LOAD1;
        end else begin
            miss_src = MISS_NONE;
        end
    end

    always_comb begin
        case (miss_src)
            MISS_STORE: miss_tag = store_req.tag;
            MISS_LOAD0: miss_tag = read_addrs[0].tag;
            MISS_LOAD1: miss_tag = read_addrs[1].tag;
            default:    miss_tag = '0;
        endcase
    end

    assign snoop_tag = miss_tag;

    // Writeback owns the memory side this cycle, duplicates are dropped
    always_comb begin
        mem_req = '0;
        mem_req.valid = (miss_src != MISS_NONE) && !mem_wb_valid && !mshr_found;
        mem_req.tag = miss_tag;
    end

    always_comb begin
        new_entry.valid = mem_req.valid && mem_req_accepted && (current_req_tag != '0);
        new_entry.mem_tag = current_req_tag;
        new_entry.tag = mem_req.tag;
    end

endmodule

// File: hw/dcache_subsystem.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_subsystem
    import dcache_pkg::*;
(
    input  logic                                 clock,
    input  logic                                 reset,

    // Loads, port 0 is the older operation
    input  addr_pkt_t [`DCACHE_READ_PORTS-1:0]   read_addrs,
    output lookup_t   [`DCACHE_READ_PORTS-1:0]   cache_outs,

    // Store port
    input  logic                                 store_valid,
    input  logic [`DCACHE_ADDR_BITS-1:0]         store_addr,
    input  logic [`DCACHE_WORD_BITS-1:0]         store_data,
    output logic                                 store_done,

    // Memory read request and return
    output addr_pkt_t                            mem_req,
    input  logic                                 mem_req_accepted,
    input  logic [`DCACHE_MEM_TAG_BITS-1:0]      current_req_tag,
    input  line_data_t                           mem_data,
    input  logic [`DCACHE_MEM_TAG_BITS-1:0]      mem_data_tag,

    // Dirty writeback
    output mem_wb_t                              mem_wb
);

    store_req_t                  store_req;
    logic                        store_en;
    logic                        store_hit;
    addr_pkt_t                   refill;
    logic [`DCACHE_TAG_BITS-1:0] snoop_tag;
    logic                        mshr_found;
    mshr_entry_t                 new_entry;

    dcache_lines i_dcache_lines (
        .clock      (clock),
        .reset      (reset),
        .read_addrs (read_addrs),
        .cache_outs (cache_outs),
        .store_req  (store_req),
        .store_en   (store_en),
        .store_hit  (store_hit),
        .refill     (refill),
        .refill_data(mem_data),
        .mem_wb     (mem_wb)
    );

    dcache_mshr i_dcache_mshr (
        .clock       (clock),
        .reset       (reset),
        .snoop_tag   (snoop_tag),
        .found       (mshr_found),
        .new_entry   (new_entry),
        .mem_data_tag(mem_data_tag),
        .refill      (refill)
    );

    dcache_miss_ctrl i_dcache_miss_ctrl (
        .store_valid     (store_valid),
        .store_addr      (store_addr),
        .store_data      (store_data),
        .read_addrs      (read_addrs),
        .cache_outs      (cache_outs),
        .store_hit       (store_hit),
        .refill_active   (refill.valid),
        .mshr_found      (mshr_found),
        .mem_wb_valid    (mem_wb.valid),
        .mem_req_accepted(mem_req_accepted),
        .current_req_tag (current_req_tag),
        .store_req       (store_req),
        .store_en        (store_en),
        .store_done      (store_done),
        .snoop_tag       (snoop_tag),
        .mem_req         (mem_req),
        .new_entry       (new_entry)
    );

endmodule

// File: tb/dcache_mem_model.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_mem_model
    import dcache_pkg::*;
(
    input  logic                            clock,
    input  logic                            reset,
    input  addr_pkt_t                       mem_req,
    output logic                            mem_req_accepted,
    output logic [`DCACHE_MEM_TAG_BITS-1:0] current_req_tag,
    output line_data_t                      mem_data,
    output logic [`DCACHE_MEM_TAG_BITS-1:0] mem_data_tag,
    input  mem_wb_t                         mem_wb
);

    localparam logic [`DCACHE_MEM_TAG_BITS-1:0] FIRST_TAG =
        {{(`DCACHE_MEM_TAG_BITS-1){1'b0}}, 1'b1};

    mshr_entry_t                     pending[$];
    line_data_t                      written[logic [`DCACHE_TAG_BITS-1:0]];
    logic [`DCACHE_MEM_TAG_BITS-1:0] next_tag;
    int                              delay;

    // Untouched lines hold their tag in both words
    function automatic line_data_t line_value(input logic [`DCACHE_TAG_BITS-1:0] tag);
        if (written.exists(tag)) begin
            return written[tag];
        end
        return {2{3'b000, tag}};
    endfunction

    // Outputs change on the falling edge only
    initial begin
        mem_req_accepted = 1'b0;
        current_req_tag = '0;
        mem_data = '0;
        mem_data_tag = '0;
        delay = 0;
        forever begin
            @(negedge clock);
            if (!reset) begin
                mem_req_accepted = 1'b0;
                mem_data_tag = '0;
                delay = 2;
            end else begin
                // Never more requests in flight than the miss table holds
                mem_req_accepted = (pending.size() < `DCACHE_MSHR_DEPTH) &&
                                   ($urandom_range(0, 3) != 0);
                current_req_tag = next_tag;
                if (mem_data_tag != '0 || pending.size() == 0) begin
                    mem_data_tag = '0;
                end else if (delay > 0) begin
                    delay--;
                end else begin
                    mem_data_tag = pending[0].mem_tag;
                    mem_data = line_value(pending[0].tag);
                    delay = $urandom_range(0, 4);
                end
            end
        end
    end

    always @(posedge clock) begin
        mshr_entry_t entry;
        if (!reset) begin
            pending.delete();
            next_tag = FIRST_TAG;
        end else begin
            // Returns come back in request order
            if (mem_data_tag != '0) begin
                void'(pending.pop_front());
            end
            if (mem_req.valid && mem_req_accepted) begin
                entry.valid = 1'b1;
                entry.mem_tag = current_req_tag;
                entry.tag = mem_req.tag;
                pending.push_back(entry);
                next_tag = (next_tag == '1) ? FIRST_TAG : next_tag + FIRST_TAG;
            end
            if (mem_wb.valid) begin
                written[mem_wb.tag] = mem_wb.data;
            end
        end
    end

endmodule

// File: tb/dcache_tb.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_tb
    import dcache_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 400;
    localparam int REF_LINES = 32;
    localparam logic [31:0] SEED = 32'h232;

    logic                                clock = 1'b0;
    logic                                reset;
    addr_pkt_t [`DCACHE_READ_PORTS-1:0]  read_addrs;
    lookup_t   [`DCACHE_READ_PORTS-1:0]  cache_outs;
    logic                                store_valid;
    logic [`DCACHE_ADDR_BITS-1:0]        store_addr;
    logic [`DCACHE_WORD_BITS-1:0]        store_data;
    logic                                store_done;
    addr_pkt_t                           mem_req;
    logic                                mem_req_accepted;
    logic [`DCACHE_MEM_TAG_BITS-1:0]     current_req_tag;
    line_data_t                          mem_data;
    logic [`DCACHE_MEM_TAG_BITS-1:0]     mem_data_tag;
    mem_wb_t                             mem_wb;

    // Reference state per line, the stimulus only uses line tags below 32
    line_data_t ref_data [REF_LINES];
    logic       ref_dirty [REF_LINES];
    logic       pend [REF_LINES];
    logic [4:0] fill_q[$];
    logic       fill_valid;
    logic [4:0] fill_tag;
    line_data_t exp_load [`DCACHE_READ_PORTS];
    logic       store_expect_hit;

    int errors = 0;
    int loads_hit = 0;
    int stores_done = 0;
    int writebacks = 0;

    always #4 clock = ~clock;

    dcache_subsystem i_dcache_subsystem (
        .clock           (clock),
        .reset           (reset),
        .read_addrs      (read_addrs),
        .cache_outs      (cache_outs),
        .store_valid     (store_valid),
        .store_addr      (store_addr),
        .store_data      (store_data),
        .store_done      (store_done),
        .mem_req         (mem_req),
        .mem_req_accepted(mem_req_accepted),
        .current_req_tag (current_req_tag),
        .mem_data        (mem_data),
        .mem_data_tag    (mem_data_tag),
        .mem_wb          (mem_wb)
    );

    dcache_mem_model i_mem_model (
        .clock           (clock),
        .reset           (reset),
        .mem_req         (mem_req),
        .mem_req_accepted(mem_req_accepted),
        .current_req_tag (current_req_tag),
        .mem_data        (mem_data),
        .mem_data_tag    (mem_data_tag),
        .mem_wb          (mem_wb)
    );

    task automatic report_value(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
        errors++;
        $display("FAILED %s expected %h actual %h", name, expected, actual);
    endtask

    task automatic report_event(input string what);
        errors++;
        $display("at %0t ns: %s", $time, what);
    endtask

    // Reference model, follows completed stores, refills and writebacks
    always @(posedge clock) begin
        line_data_t new_line;
        logic [4:0] st_line;
        if (!reset) begin
            for (int i = 0; i < REF_LINES; i++) begin
                ref_data[i] <= {2{3'b000, 29'(i)}};
                ref_dirty[i] <= 1'b0;
                pend[i] <= 1'b0;
            end
            fill_q.delete();
            fill_valid <= 1'b0;
        end else begin
            if (store_done) begin
                st_line = store_addr[7:3];
                new_line = ref_data[st_line];
                if (store_addr[2]) begin
                    new_line[7:4] = store_data;
                end else begin
                    new_line[3:0] = store_data;
                end
                ref_data[st_line] <= new_line;
                ref_dirty[st_line] <= ref_dirty[st_line] || (new_line != ref_data[st_line]);
            end
            if (mem_wb.valid) begin
                ref_dirty[mem_wb.tag[4:0]] <= 1'b0;
                writebacks <= writebacks + 1;
            end
            fill_valid <= 1'b0;
            if (mem_data_tag != '0) begin
                pend[fill_q[0]] <= 1'b0;
                fill_valid <= 1'b1;
                fill_tag <= fill_q[0];
                void'(fill_q.pop_front());
            end
            if (mem_req.valid && mem_req_accepted) begin
                pend[mem_req.tag[4:0]] <= 1'b1;
                fill_q.push_back(mem_req.tag[4:0]);
            end
        end
    end

    always_comb begin
        for (int p = 0; p < `DCACHE_READ_PORTS; p++) begin
            exp_load[p] = ref_data[read_addrs[p].tag[4:0]];
        end
    end

    load0_data: assert property (@(posedge clock) disable iff (!reset)
        (read_addrs[0].valid && cache_outs[0].valid) |-> (cache_outs[0].data == exp_load[0]))
        else report_value("load0_data", $sampled(exp_load[0]), $sampled(cache_outs[0].data));

    load1_data: assert property (@(posedge clock) disable iff (!reset)
        (read_addrs[1].valid && cache_outs[1].valid) |-> (cache_outs[1].data == exp_load[1]))
        else report_value("load1_data", $sampled(exp_load[1]), $sampled(cache_outs[1].data));

    // A line refilled at the last edge hits now
    fill_hit: assert property (@(posedge clock) disable iff (!reset)
        (read_addrs[0].valid && fill_valid && read_addrs[0].tag == 29'(fill_tag))
        |-> cache_outs[0].valid)
        else report_event("line refilled at the last edge missed on load port 0");

    miss_request: assert property (@(posedge clock) disable iff (!reset)
        (read_addrs[0].valid && !cache_outs[0].valid && !store_valid && !mem_wb.valid &&
         !pend[read_addrs[0].tag[4:0]])
        |-> (mem_req.valid && mem_req.tag == read_addrs[0].tag))
        else report_value("miss_request", 64'({1'b1, $sampled(read_addrs[0].tag)}),
                          64'({$sampled(mem_req.valid), $sampled(mem_req.tag)}));

    store_miss_first: assert property (@(posedge clock) disable iff (!reset)
        (store_valid && !store_done && mem_data_tag == '0 && !mem_wb.valid &&
         !pend[store_addr[7:3]])
        |-> (mem_req.valid && mem_req.tag == store_addr[31:3]))
        else report_value("store_miss_first", 64'({1'b1, $sampled(store_addr[31:3])}),
                          64'({$sampled(mem_req.valid), $sampled(mem_req.tag)}));

    req_offset: assert property (@(posedge clock) disable iff (!reset)
        mem_req.valid |-> (mem_req.offset == '0))
        else report_value("req_offset", 64'(0), 64'($sampled(mem_req.offset)));

    no_dup: assert property (@(posedge clock) disable iff (!reset)
        (mem_req.valid && mem_req_accepted) |-> !pend[mem_req.tag[4:0]])
        else report_event("second request accepted for a line already outstanding");

    store_hit_done: assert property (@(posedge clock) disable iff (!reset)
        (store_valid && store_expect_hit) |-> store_done)
        else report_event("store to a resident line did not complete at once");

    wb_blocks_req: assert property (@(posedge clock) disable iff (!reset)
        mem_wb.valid |-> !mem_req.valid)
        else report_event("read request issued in a writeback cycle");

    wb_dirty: assert property (@(posedge clock) disable iff (!reset)
        mem_wb.valid |-> ref_dirty[mem_wb.tag[4:0]])
        else report_event("clean line written back");

    wb_data: assert property (@(posedge clock) disable iff (!reset)
        mem_wb.valid |-> (mem_wb.data == ref_data[mem_wb.tag[4:0]]))
        else report_value("wb_data", $sampled(ref_data[mem_wb.tag[4:0]]), $sampled(mem_wb.data));

    // Holds loads until every enabled port has hit once
    task automatic run_loads(input logic [4:0] tag0, input logic use0,
                             input logic [4:0] tag1, input logic use1);
        int   cycles;
        logic done0;
        logic done1;
        @(negedge clock);
        read_addrs[0] = {use0, 29'(tag0), 3'b000};
        read_addrs[1] = {use1, 29'(tag1), 3'b000};
        done0 = !use0;
        done1 = !use1;
        cycles = 0;
        while (!(done0 && done1) && cycles < TIMEOUT_CYCLES) begin
            @(posedge clock);
            done0 = done0 || cache_outs[0].valid;
            done1 = done1 || cache_outs[1].valid;
            cycles++;
        end
        if (!(done0 && done1)) begin
            report_event($sformatf("load of line %0d or %0d never hit", tag0, tag1));
        end else begin
            loads_hit += int'(use0) + int'(use1);
        end
        @(negedge clock);
        read_addrs = '0;
    endtask

    // Holds a store until it completes, the DUT only writes on a hit
    task automatic do_store(input logic [4:0] tag, input logic upper,
                            input logic [31:0] data, input logic expect_hit);
        int   cycles;
        logic done;
        @(negedge clock);
        store_valid = 1'b1;
        store_addr = {24'b0, tag, upper, 2'b00};
        store_data = data;
        store_expect_hit = expect_hit;
        done = 1'b0;
        cycles = 0;
        while (!done && cycles < TIMEOUT_CYCLES) begin
            @(posedge clock);
            done = store_done;
            cycles++;
        end
        if (!done) begin
            report_event($sformatf("store to line %0d never completed", tag));
        end else begin
            stores_done++;
        end
        @(negedge clock);
        store_valid = 1'b0;
        store_expect_hit = 1'b0;
    endtask

    initial begin
        logic [4:0] tag;
        void'($urandom(SEED));
        reset = 1'b0;
        read_addrs = '0;
        store_valid = 1'b0;
        store_addr = '0;
        store_data = '0;
        store_expect_hit = 1'b0;
        repeat (5) @(negedge clock);
        reset = 1'b1;

        run_loads(5'd1, 1'b1, 5'd0, 1'b0);
        // Both ports and a store on one outstanding line
        fork
            run_loads(5'd2, 1'b1, 5'd2, 1'b1);
            do_store(5'd2, 1'b0, 32'h1234_5678, 1'b0);
        join
        do_store(5'd1, 1'b1, 32'hdead_beef, 1'b1);
        run_loads(5'd1, 1'b1, 5'd2, 1'b1);
        // Store miss against two load misses
        fork
            do_store(5'd3, 1'b0, 32'hcafe_0003, 1'b0);
            run_loads(5'd4, 1'b1, 5'd5, 1'b1);
        join

        // More lines than the cache holds, forces dirty evictions
        for (int i = 0; i < 40; i++) begin
            tag = 5'($urandom_range(1, 20));
            if ($urandom_range(0, 1) == 1) begin
                do_store(tag, 1'($urandom_range(0, 1)), $urandom(), 1'b0);
            end else begin
                run_loads(tag, 1'b1, 5'($urandom_range(1, 20)), 1'b1);
            end
        end
        for (int t = 1; t <= 20; t += 2) begin
            run_loads(5'(t), 1'b1, 5'(t + 1), 1'b1);
        end

        repeat (2) @(negedge clock);
        // Writeback checks only count if some dirty line was evicted
        if (writebacks == 0) begin
            report_event("no dirty line was ever written back");
        end
        $display("loads %0d, stores %0d, writebacks %0d, errors %0d",
                 loads_hit, stores_done, writebacks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_replace.sv
hw/dcache_lines.sv
hw/dcache_mshr.sv
hw/dcache_miss_ctrl.sv
hw/dcache_subsystem.sv
tb/dcache_mem_model.sv
tb/dcache_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = dcache_tb
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = TEST PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
